// ==== include/csr_config.svh ====
/*
 * Register map and fixed constants of the accelerator CSR front end.
 * Include this wherever an offset, the ID value or a statistic index is needed.
 */

`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Width of the dword MMIO address as it arrives from the host
`define CSR_MMIO_ADDR_BITS 16

// Register byte offsets in the MMIO space
`define CSR_AFU_ID        12'h000
`define CSR_AFU_SCRATCH   12'h020
`define CSR_AFU_DSM_BASE  12'h110
`define CSR_AFU_SREG_READ 12'h140

// Value returned by a read of the ID register
`define CSR_AFU_ID_VALUE 64'h3c5e_a17f_0d28_9b64

// Statistic indices selected through the SREG_READ register
`define CSR_SREG_WR_COUNT  0
`define CSR_SREG_RD_COUNT  1
`define CSR_SREG_DSM_COUNT 2

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Builds the CSR front end testbench with Verilator and runs it.
# The run counts as passed only if the log holds the pass line.
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"

verilator --binary -j 0 --top-module tb_afu_csr -f src.f -Mdir "$BUILD_DIR/obj_dir"

"$BUILD_DIR/obj_dir/Vtb_afu_csr" > "$LOG" 2>&1

cat "$LOG"

if grep -qx "Simulation PASSED" "$LOG"; then
    echo "Run passed"
    exit 0
fi

echo "Run failed, see $LOG"
exit 1

// ==== src.f ====
+incdir+include
src/csr_pkg.sv
src/csr_write_decoder.sv
src/csr_statistics.sv
src/csr_read_responder.sv
src/afu_csr_top.sv
verification/tb_afu_csr.sv

// ==== src/afu_csr_top.sv ====
/*
 * Top level of the accelerator CSR front end.
 * Host MMIO strobes go in, one read response per read comes out a cycle later.
 */

`timescale 1ns/1ps
`default_nettype none

module afu_csr_top
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                mmio_wr,
    input  logic                mmio_rd,
    input  csr_pkg::mmio_hdr_t  mmio_hdr,
    input  csr_pkg::mmio_data_t mmio_data,
    output logic                rsp_valid,
    output csr_pkg::mmio_rsp_t  rsp
);

    import csr_pkg::*;

    // Register state shared by the statistics and the read path
    csr_state_t  csr_state;
    // Counter picked by the current status-register select
    logic [63:0] sreg_value;

    // Writes update the register state one cycle after their strobe
    csr_write_decoder i_write_decoder
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .mmio_wr   (mmio_wr),
        .mmio_hdr  (mmio_hdr),
        .mmio_data (mmio_data),
        .csr       (csr_state)
    );

    csr_statistics i_statistics
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .mmio_wr    (mmio_wr),
        .mmio_rd    (mmio_rd),
        .csr        (csr_state),
        .sreg_value (sreg_value)
    );

    // Reads see the state as it stands when the strobe is sampled
    csr_read_responder i_read_responder
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .mmio_rd    (mmio_rd),
        .mmio_hdr   (mmio_hdr),
        .csr        (csr_state),
        .sreg_value (sreg_value),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

endmodule

`default_nettype wire

// ==== src/csr_pkg.sv ====
/*
 * Shared types of the CSR front end.
 * Every module imports this package to get the request, response and
 * broadcast register state types.
 */

`default_nettype none

`include "csr_config.svh"

package csr_pkg;

    // Dword address, the two low byte-address bits are never sent
    typedef logic [`CSR_MMIO_ADDR_BITS-1:0] mmio_addr_t;

    // Request header that comes with every MMIO read or write
    typedef struct packed {
        mmio_addr_t  addr;
        // Set when the access carries the full 64 bits
        logic        is_64;
        logic [7:0]  tid;
    } mmio_hdr_t;

    // The same 64-bit data word seen either whole or as two dwords
    // A 32-bit access only uses dword[0]
    typedef union packed {
        logic [63:0]      qword;
        logic [1:0][31:0] dword;
    } mmio_data_t;

    // Cache-line physical address, a byte address without its low 6 bits
    typedef logic [57:0] cl_paddr_t;

    // Index of the statistic that an SREG_READ read returns
    typedef logic [7:0] sreg_addr_t;

    // Register state broadcast from the write decoder to all consumers
    typedef struct packed {
        logic [63:0] scratch;
        cl_paddr_t   dsm_base;
        // Low while only the high half of a split write has arrived
        logic        dsm_base_valid;
        // One-cycle pulse when the DSM base becomes complete
        logic        dsm_update;
        sreg_addr_t  sreg_addr;
    } csr_state_t;

    // Response to one MMIO read
    typedef struct packed {
        logic [7:0] tid;
        mmio_data_t data;
    } mmio_rsp_t;

endpackage

`default_nettype wire

// ==== src/csr_read_responder.sv ====
/*
 * Answers host MMIO reads from the broadcast CSR state.
 * Each read strobe yields one registered response on the next cycle,
 * carrying the request's tid.
 */

`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_read_responder
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                mmio_rd,
    input  csr_pkg::mmio_hdr_t  mmio_hdr,
    input  csr_pkg::csr_state_t csr,
    input  logic [63:0]         sreg_value,
    output logic                rsp_valid,
    output csr_pkg::mmio_rsp_t  rsp
);

    import csr_pkg::*;

    // Dword addresses of the readable registers
    localparam mmio_addr_t ID_ADDR      = mmio_addr_t'(`CSR_AFU_ID >> 2);
    localparam mmio_addr_t SCRATCH_ADDR = mmio_addr_t'(`CSR_AFU_SCRATCH >> 2);
    localparam mmio_addr_t DSM_ADDR     = mmio_addr_t'(`CSR_AFU_DSM_BASE >> 2);
    localparam mmio_addr_t SREG_ADDR    = mmio_addr_t'(`CSR_AFU_SREG_READ >> 2);

    mmio_addr_t  rd_addr;
    logic [63:0] rd_value;

    // Every readable register is 64 bits wide, so either dword of it
    // returns the whole value
    always_comb
    begin
        rd_addr    = mmio_hdr.addr;
        rd_addr[0] = 1'b0;
    end

    // Pick the value for the current read address
    always_comb
    begin
        case (rd_addr)
            ID_ADDR:
                rd_value = `CSR_AFU_ID_VALUE;
            SCRATCH_ADDR:
                rd_value = csr.scratch;
            // Restore the byte address by appending the cache-line offset
            DSM_ADDR:
                rd_value = {csr.dsm_base, 6'b0};
            // Statistic chosen by the last SREG_READ write
            SREG_ADDR:
                rd_value = sreg_value;
            default:
                rd_value = '0;
        endcase
    end

    // One response per read, one cycle later, so back-to-back reads
    // stream out back-to-back
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= mmio_rd;
    end

    // Response payload is only meaningful while rsp_valid is high
    always_ff @(posedge clk)
    begin
        if (mmio_rd)
        begin
            rsp.tid        <= mmio_hdr.tid;
            rsp.data.qword <= rd_value;
        end
    end

endmodule

`default_nettype wire

// ==== src/csr_statistics.sv ====
/*
 * Event counters for the CSR front end.
 * Counts MMIO writes, MMIO reads and completed DSM base updates, and
 * presents the one named by the status-register select.
 */

`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_statistics
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                mmio_wr,
    input  logic                mmio_rd,
    input  csr_pkg::csr_state_t csr,
    output logic [63:0]         sreg_value
);

    import csr_pkg::*;

    logic [63:0] wr_count;
    logic [63:0] rd_count;
    logic [63:0] dsm_count;

    // Counters step on the edge after their event, so a read sampled in
    // the same cycle sees the count without itself
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_count  <= '0;
            rd_count  <= '0;
            dsm_count <= '0;
        end
        else
        begin
            if (mmio_wr)
                wr_count <= wr_count + 64'd1;
            if (mmio_rd)
                rd_count <= rd_count + 64'd1;
            // The pulse already lags its write by one cycle
            if (csr.dsm_update)
                dsm_count <= dsm_count + 64'd1;
        end
    end

    // Select the requested counter, unknown indices read as zero
    always_comb
    begin
        case (csr.sreg_addr)
            sreg_addr_t'(`CSR_SREG_WR_COUNT):
                sreg_value = wr_count;
            sreg_addr_t'(`CSR_SREG_RD_COUNT):
                sreg_value = rd_count;
            sreg_addr_t'(`CSR_SREG_DSM_COUNT):
                sreg_value = dsm_count;
            default:
                sreg_value = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/csr_write_decoder.sv ====
/*
 * Decodes host MMIO writes into the broadcast CSR state.
 * 64-bit registers accept either one 64-bit write or two 32-bit writes
 * with the high half sent first.
 */

`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_write_decoder
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                mmio_wr,
    input  csr_pkg::mmio_hdr_t  mmio_hdr,
    input  csr_pkg::mmio_data_t mmio_data,
    output csr_pkg::csr_state_t csr
);

    import csr_pkg::*;

    // Register offsets turned into dword addresses
    localparam mmio_addr_t SCRATCH_ADDR = mmio_addr_t'(`CSR_AFU_SCRATCH >> 2);
    localparam mmio_addr_t DSM_ADDR     = mmio_addr_t'(`CSR_AFU_DSM_BASE >> 2);
    localparam mmio_addr_t SREG_ADDR    = mmio_addr_t'(`CSR_AFU_SREG_READ >> 2);

    logic [63:0] scratch_q;
    cl_paddr_t   dsm_base_q;
    logic        dsm_valid_q;
    logic        dsm_update_q;
    sreg_addr_t  sreg_addr_q;

    logic        hit_scratch;
    logic        hit_dsm;
    logic        hit_sreg;
    logic        hi_half;
    logic [31:0] wr_dword;

    // A 32-bit register matches only on its exact dword address
    function automatic logic match32(input mmio_addr_t addr, input mmio_addr_t tgt);
        return addr == tgt;
    endfunction

    // A 64-bit register also takes the upper dword of a split write,
    // so the low address bit is dropped before comparing
    function automatic logic match64(input mmio_addr_t addr, input mmio_addr_t tgt);
        mmio_addr_t base;
        base = addr;
        base[0] = 1'b0;
        return base == tgt;
    endfunction

    assign hit_scratch = mmio_wr && match64(mmio_hdr.addr, SCRATCH_ADDR);
    assign hit_dsm     = mmio_wr && match64(mmio_hdr.addr, DSM_ADDR);
    assign hit_sreg    = mmio_wr && match32(mmio_hdr.addr, SREG_ADDR);

    // Address bit 0 marks the upper dword of a split 64-bit write
    assign hi_half  = mmio_hdr.addr[0];
    assign wr_dword = mmio_data.dword[0];

    // Scratch register, whole or one half at a time
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            scratch_q <= '0;
        else if (hit_scratch)
        begin
            if (mmio_hdr.is_64)
                scratch_q <= mmio_data.qword;
            else if (hi_half)
                scratch_q[63:32] <= wr_dword;
            else
                scratch_q[31:0] <= wr_dword;
        end
    end

    // DSM base address
    // The cache-line address drops byte bits 5:0, so the low dword only
    // supplies bits 25:0 and the high dword supplies bits 57:26
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            dsm_base_q  <= '0;
            dsm_valid_q <= 1'b0;
        end
        else if (hit_dsm)
        begin
            if (mmio_hdr.is_64)
                dsm_base_q <= mmio_data.qword[63:6];
            else if (hi_half)
                dsm_base_q[57:26] <= wr_dword;
            else
                dsm_base_q[25:0] <= wr_dword[31:6];
            // The low half comes last, so its arrival completes the register
            dsm_valid_q <= ~hi_half;
        end
    end

    // Pulse for exactly one cycle each time the base is written valid
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            dsm_update_q <= 1'b0;
        else
            dsm_update_q <= hit_dsm && !hi_half;
    end

    // Statistic select, read back later through the same offset
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            sreg_addr_q <= '0;
        else if (hit_sreg)
            sreg_addr_q <= wr_dword[7:0];
    end

    always_comb
    begin
        csr.scratch        = scratch_q;
        csr.dsm_base       = dsm_base_q;
        csr.dsm_base_valid = dsm_valid_q;
        csr.dsm_update     = dsm_update_q;
        csr.sreg_addr      = sreg_addr_q;
    end

endmodule

`default_nettype wire

// ==== verification/tb_afu_csr.sv ====
/*
 * Testbench for the accelerator CSR front end.
 * Applies a table of MMIO writes and reads to the top level and checks each
 * read response against a reference model of the register map.
 */

`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module tb_afu_csr;

    import csr_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam bit OP_WR        = 1'b0;
    localparam bit OP_RD        = 1'b1;

    // One row of the stimulus table
    typedef struct packed {
        logic        op;
        logic [11:0] offset;
        logic        is_64;
        logic [63:0] data;
        logic [63:0] expected;
    } test_entry_t;

    logic        clk;
    logic        reset_n;
    logic        mmio_wr;
    logic        mmio_rd;
    mmio_hdr_t   mmio_hdr;
    mmio_data_t  mmio_data;
    logic        rsp_valid;
    mmio_rsp_t   rsp;

    test_entry_t tests[$];
    logic        table_ready;
    int          error_count;
    int          pass_count;
    int          fail_count;

    // Reference model copies of the registers and counters
    // The DSM base is kept as a byte address with its low six bits zero
    logic [63:0] m_scratch;
    logic [63:0] m_dsm;
    logic [7:0]  m_sreg;
    logic [63:0] m_wr_count;
    logic [63:0] m_rd_count;
    logic [63:0] m_dsm_count;

    afu_csr_top i_dut
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .mmio_wr   (mmio_wr),
        .mmio_rd   (mmio_rd),
        .mmio_hdr  (mmio_hdr),
        .mmio_data (mmio_data),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    // 100 ns clock period
    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;
    end

    task automatic add_entry(input logic op, input logic [11:0] offset,
                             input logic is_64, input logic [63:0] data);
        test_entry_t e;
        e.op       = op;
        e.offset   = offset;
        e.is_64    = is_64;
        e.data     = data;
        e.expected = '0;
        tests.push_back(e);
    endtask

    // Register update rules of the write decoder, applied to the model
    task automatic model_write(input logic [11:0] offset, input logic is_64,
                               input logic [63:0] data);
        logic [11:0] base;
        logic        hi;
        // Byte offset bit 2 is dword address bit 0, the upper half of a 64-bit register
        base = offset & ~12'h004;
        hi   = offset[2];
        m_wr_count = m_wr_count + 64'd1;
        if (base == `CSR_AFU_SCRATCH)
        begin
            if (is_64)
                m_scratch = data;
            else if (hi)
                m_scratch[63:32] = data[31:0];
            else
                m_scratch[31:0] = data[31:0];
        end
        else if (base == `CSR_AFU_DSM_BASE)
        begin
            if (is_64)
                m_dsm = {data[63:6], 6'b0};
            else if (hi)
                m_dsm[63:32] = data[31:0];
            else
                m_dsm[31:6] = data[31:6];
            // Writing the low half (or the whole word) completes the base
            if (!hi)
                m_dsm_count = m_dsm_count + 64'd1;
        end
        else if (offset == `CSR_AFU_SREG_READ)
            m_sreg = data[7:0];
    endtask

    // Value that a read returns, counted only after the value is taken
    task automatic model_read(input logic [11:0] offset, output logic [63:0] value);
        logic [11:0] base;
        base = offset & ~12'h004;
        if (base == `CSR_AFU_ID)
            value = `CSR_AFU_ID_VALUE;
        else if (base == `CSR_AFU_SCRATCH)
            value = m_scratch;
        else if (base == `CSR_AFU_DSM_BASE)
            value = m_dsm;
        else if (base == `CSR_AFU_SREG_READ)
        begin
            if (m_sreg == 8'(`CSR_SREG_WR_COUNT))
                value = m_wr_count;
            else if (m_sreg == 8'(`CSR_SREG_RD_COUNT))
                value = m_rd_count;
            else if (m_sreg == 8'(`CSR_SREG_DSM_COUNT))
                value = m_dsm_count;
            else
                value = '0;
        end
        else
            value = '0;
        m_rd_count = m_rd_count + 64'd1;
    endtask

    task automatic build_table();
        logic [63:0] pattern;
        int          i;
        // Reset values of the mapped registers
        add_entry(OP_RD, `CSR_AFU_ID, 1'b1, '0);
        add_entry(OP_RD, `CSR_AFU_SCRATCH, 1'b1, '0);
        add_entry(OP_RD, `CSR_AFU_DSM_BASE, 1'b1, '0);
        add_entry(OP_RD, `CSR_AFU_SREG_READ, 1'b1, '0);
        // Random scratch patterns, each read straight back
        for (i = 0; i < 3; i++)
        begin
            pattern = {$urandom(), $urandom()};
            add_entry(OP_WR, `CSR_AFU_SCRATCH, 1'b1, pattern);
            add_entry(OP_RD, `CSR_AFU_SCRATCH, 1'b1, '0);
        end
        // Nothing lives at this offset
        add_entry(OP_RD, 12'h0a8, 1'b1, '0);
        // Whole DSM base, low six bits are dropped
        add_entry(OP_WR, `CSR_AFU_DSM_BASE, 1'b1, 64'h0000_7f3a_5c81_d2ff);
        add_entry(OP_RD, `CSR_AFU_DSM_BASE, 1'b1, '0);
        // Split DSM base, high half first with junk in the unused upper dword
        add_entry(OP_WR, `CSR_AFU_DSM_BASE + 12'h004, 1'b0, 64'hffff_ffff_0bad_f00d);
        add_entry(OP_RD, `CSR_AFU_DSM_BASE, 1'b1, '0);
        add_entry(OP_WR, `CSR_AFU_DSM_BASE, 1'b0, 64'h0000_0000_2468_ace5);
        add_entry(OP_RD, `CSR_AFU_DSM_BASE + 12'h004, 1'b1, '0);
        // Walk the statistic select, index 5 names no counter
        add_entry(OP_WR, `CSR_AFU_SREG_READ, 1'b0, 64'(`CSR_SREG_WR_COUNT));
        add_entry(OP_RD, `CSR_AFU_SREG_READ, 1'b1, '0);
        add_entry(OP_WR, `CSR_AFU_SREG_READ, 1'b0, 64'(`CSR_SREG_RD_COUNT));
        add_entry(OP_RD, `CSR_AFU_SREG_READ, 1'b1, '0);
        add_entry(OP_WR, `CSR_AFU_SREG_READ, 1'b0, 64'(`CSR_SREG_DSM_COUNT));
        add_entry(OP_RD, `CSR_AFU_SREG_READ, 1'b1, '0);
        add_entry(OP_WR, `CSR_AFU_SREG_READ, 1'b0, 64'd5);
        add_entry(OP_RD, `CSR_AFU_SREG_READ, 1'b1, '0);
    endtask

    // The idle cycle between entries lets every earlier write and DSM update
    // settle, so the model can be walked in table order
    task automatic fill_expected();
        test_entry_t e;
        logic [63:0] value;
        int          i;
        for (i = 0; i < tests.size(); i++)
        begin
            e = tests[i];
            value = '0;
            if (e.op == OP_WR)
                model_write(e.offset, e.is_64, e.data);
            else
                model_read(e.offset, value);
            e.expected = value;
            tests[i] = e;
        end
    endtask

    task automatic drive_request(input logic op, input logic [11:0] offset, input logic is_64,
                                 input logic [63:0] data, input logic [7:0] tid);
        mmio_wr         = (op == OP_WR);
        mmio_rd         = (op == OP_RD);
        mmio_hdr.addr   = mmio_addr_t'(offset >> 2);
        mmio_hdr.is_64  = is_64;
        mmio_hdr.tid    = tid;
        mmio_data.qword = data;
    endtask

    task automatic drive_idle();
        mmio_wr = 1'b0;
        mmio_rd = 1'b0;
    endtask

    // Called one falling edge after the read was driven
    task automatic check_response(input logic [7:0] tid, input logic [63:0] expected,
                                  output bit ok);
        ok = 1'b1;
        if (rsp_valid !== 1'b1)
        begin
            $display("No read response arrived one cycle after the read with tid %0d", tid);
            error_count++;
            ok = 1'b0;
        end
        else
        begin
            if (rsp.tid !== tid)
            begin
                $display("[ERROR] %t: tid %0h, expected %0h", $time, rsp.tid, tid);
                error_count++;
                ok = 1'b0;
            end
            if (rsp.data.qword !== expected)
            begin
                $display("[ERROR] %t: read data %h, expected %h", $time,
                         rsp.data.qword, expected);
                error_count++;
                ok = 1'b0;
            end
        end
    endtask

    task automatic check_idle(output bit ok);
        ok = 1'b1;
        if (rsp_valid !== 1'b0)
        begin
            $display("[ERROR] %t: rsp_valid high with no read in the cycle before", $time);
            error_count++;
            ok = 1'b0;
        end
    endtask

    // Four reads on consecutive cycles, each response checked as it streams out
    task automatic run_burst(output bit ok);
        logic [11:0] offsets[4];
        logic [63:0] expected[4];
        bit          step_ok;
        int          b;
        offsets[0] = `CSR_AFU_ID;
        offsets[1] = `CSR_AFU_SCRATCH;
        offsets[2] = `CSR_AFU_DSM_BASE + 12'h004;
        offsets[3] = `CSR_AFU_SREG_READ;
        ok = 1'b1;
        @(negedge clk);
        check_idle(step_ok);
        ok &= step_ok;
        for (b = 0; b < 4; b++)
        begin
            model_read(offsets[b], expected[b]);
            drive_request(OP_RD, offsets[b], 1'b1, '0, 8'ha0 + 8'(b));
            @(negedge clk);
            check_response(8'ha0 + 8'(b), expected[b], step_ok);
            ok &= step_ok;
        end
        drive_idle();
        @(negedge clk);
        check_idle(step_ok);
        ok &= step_ok;
    endtask

    initial
    begin
        test_entry_t e;
        logic [7:0]  tid;
        bit          ok;
        bit          step_ok;
        int          idx;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'h7a5c));
        reset_n     = 1'b0;
        mmio_wr     = 1'b0;
        mmio_rd     = 1'b0;
        mmio_hdr    = '0;
        mmio_data   = '0;
        table_ready = 1'b0;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        m_scratch   = '0;
        m_dsm       = '0;
        m_sreg      = '0;
        m_wr_count  = '0;
        m_rd_count  = '0;
        m_dsm_count = '0;
        build_table();
        fill_expected();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;
        for (idx = 0; idx < tests.size(); idx++)
        begin
            e   = tests[idx];
            tid = 8'(idx);
            @(negedge clk);
            // The cycle before was idle, so no response may be showing
            check_idle(ok);
            drive_request(e.op, e.offset, e.is_64, e.data, tid);
            @(negedge clk);
            drive_idle();
            if (e.op == OP_RD)
                check_response(tid, e.expected, step_ok);
            else
                check_idle(step_ok);
            ok &= step_ok;
            if (ok)
                pass_count++;
            else
                fail_count++;
            $display("Test %0d %s offset 0x%03h: %s", idx, (e.op == OP_RD) ? "read " : "write",
                     e.offset, ok ? "ok" : "mismatch");
        end
        run_burst(ok);
        if (ok)
            pass_count++;
        else
            fail_count++;
        $display("Test %0d back-to-back reads: %s", tests.size(), ok ? "ok" : "mismatch");
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 pass_count + fail_count, pass_count, fail_count, error_count);
        if (error_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // Each table entry needs two cycles, so three per entry leaves margin
    initial
    begin
        int limit;
        wait (table_ready === 1'b1);
        limit = (tests.size() * 3) + RESET_CYCLES + 20;
        repeat (limit) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clock cycles", limit);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire
